// File: hdl/stream_pkg.sv
/*
 * Stream reduction package. Holds the stream widths, FIFO depths,
 * payload types and the FIFO status flags shared by the pipeline.
 */

package stream_pkg;

  // ------------------------------
  // widths and depths
  // ------------------------------
  localparam int unsigned DATA_WIDTH     = 32;  // stream data word
  localparam int unsigned STRB_WIDTH     = 4;   // one bit per data byte
  localparam int unsigned IN_FIFO_DEPTH  = 4;   // input beats buffered
  localparam int unsigned OUT_FIFO_DEPTH = 2;   // results buffered

  // ------------------------------
  // payload types
  // ------------------------------
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [STRB_WIDTH-1:0] strb_t;

  // beats in one burst, result side channel
  typedef logic [7:0] beat_cnt_t;

  // final beat of a burst, input side channel
  typedef logic last_t;

  // ------------------------------
  // fifo status
  // ------------------------------
  typedef struct packed {
    logic empty;  // nothing stored
    logic full;   // all entries in use
  } flags_fifo_t;

endpackage

// File: hdl/stream_fifo_sidech.sv
/*
 * Valid/ready stream FIFO with a typed side channel. Each entry holds the
 * side channel, data word and byte strobe; an empty/middle/full FSM with
 * wrapping pointers controls a register array.
 */

`timescale 1ns/1ps

module stream_fifo_sidech
  import stream_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 2,
  parameter type         SIDECH_T   = logic
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,

  output flags_fifo_t flags_o,

  // push side
  input  logic        push_valid_i,
  output logic        push_ready_o,
  input  data_t       push_data_i,
  input  strb_t       push_strb_i,
  input  SIDECH_T     push_sidech_i,

  // pop side
  output logic        pop_valid_o,
  input  logic        pop_ready_i,
  output data_t       pop_data_o,
  output strb_t       pop_strb_o,
  output SIDECH_T     pop_sidech_o
);

  localparam int unsigned ADDR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam logic [ADDR_W-1:0] LAST_PTR = ADDR_W'(FIFO_DEPTH - 1);

  typedef enum logic [1:0] {
    EMPTY,
    MIDDLE,
    FULL
  } state_e;

  typedef struct packed {
    SIDECH_T sidech;
    data_t   data;
    strb_t   strb;
  } entry_t;

  state_e            cs, ns;
  logic [ADDR_W-1:0] push_ptr_q, push_ptr_d;
  logic [ADDR_W-1:0] pop_ptr_q, pop_ptr_d;
  logic              push_en, pop_en;
  entry_t            fifo_q [FIFO_DEPTH];
  entry_t            head;

  // pointer advance, wraps at the last entry
  function automatic logic [ADDR_W-1:0] ptr_inc(input logic [ADDR_W-1:0] ptr);
    ptr_inc = (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
  endfunction

  // ------------------------------
  // handshake and flags
  // ------------------------------
  assign push_ready_o = (cs != FULL);
  assign pop_valid_o  = (cs != EMPTY);

  assign push_en = push_valid_i & push_ready_o;
  assign pop_en  = pop_valid_o & pop_ready_i;

  assign flags_o.empty = (cs == EMPTY);
  assign flags_o.full  = (cs == FULL);

  // ------------------------------
  // controller
  // ------------------------------
  always_comb begin
    ns         = cs;
    push_ptr_d = push_ptr_q;
    pop_ptr_d  = pop_ptr_q;

    if (push_en) begin
      push_ptr_d = ptr_inc(push_ptr_q);
    end
    if (pop_en) begin
      pop_ptr_d = ptr_inc(pop_ptr_q);
    end

    case (cs)
      EMPTY: begin
        if (push_en) begin
          ns = (push_ptr_d == pop_ptr_q) ? FULL : MIDDLE;  // depth 1 fills at once
        end
      end
      MIDDLE: begin
        if (push_en && !pop_en) begin
          ns = (push_ptr_d == pop_ptr_q) ? FULL : MIDDLE;
        end else if (pop_en && !push_en) begin
          ns = (pop_ptr_d == push_ptr_q) ? EMPTY : MIDDLE;
        end
      end
      FULL: begin
        if (pop_en) begin
          ns = (pop_ptr_d == push_ptr_q) ? EMPTY : MIDDLE;
        end
      end
      default: begin
        ns = EMPTY;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cs         <= EMPTY;
      push_ptr_q <= '0;
      pop_ptr_q  <= '0;
    end else if (clear_i) begin
      cs         <= EMPTY;
      push_ptr_q <= '0;
      pop_ptr_q  <= '0;
    end else begin
      cs         <= ns;
      push_ptr_q <= push_ptr_d;
      pop_ptr_q  <= pop_ptr_d;
    end
  end

  // ------------------------------
  // storage
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (push_en) begin
      fifo_q[push_ptr_q] <= '{sidech: push_sidech_i, data: push_data_i, strb: push_strb_i};
    end
  end

  assign head = fifo_q[pop_ptr_q];  // oldest entry

  // payload reads zero while nothing is offered
  assign pop_data_o   = pop_valid_o ? head.data   : '0;
  assign pop_strb_o   = pop_valid_o ? head.strb   : '0;
  assign pop_sidech_o = pop_valid_o ? head.sidech : '0;

  // ------------------------------
  // checks
  // ------------------------------
  // a write into a non-empty FIFO must never land on the unread head entry
  a_no_push_when_full: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (push_en && !pop_en && cs != EMPTY) |-> (push_ptr_q != pop_ptr_q)
  ) else $error("push accepted into a full FIFO");

  // a read from a partly filled FIFO must find an unread entry at the head
  a_no_pop_when_empty: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (pop_en && cs != FULL) |-> (push_ptr_q != pop_ptr_q)
  ) else $error("pop from an empty FIFO");

endmodule

// File: hdl/byte_accum.sv
/*
 * Burst byte accumulator. Adds the strobed bytes of every beat in a burst
 * and emits one result beat with the sum and the burst's beat count.
 */

`timescale 1ns/1ps

module byte_accum
  import stream_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,

  // input stream
  input  logic      in_valid_i,
  output logic      in_ready_o,
  input  data_t     in_data_i,
  input  strb_t     in_strb_i,
  input  last_t     in_last_i,

  // result stream
  output logic      out_valid_o,
  input  logic      out_ready_i,
  output data_t     out_sum_o,
  output strb_t     out_strb_o,
  output beat_cnt_t out_cnt_o
);

  logic      in_en, out_en;
  logic      burst_end;
  data_t     beat_sum;
  data_t     sum_next;
  beat_cnt_t cnt_next;

  data_t     sum_q;        // running burst sum
  beat_cnt_t cnt_q;        // beats taken so far
  logic      out_valid_q;
  data_t     res_sum_q;
  beat_cnt_t res_cnt_q;

  // ------------------------------
  // handshake
  // ------------------------------
  // input stalls only while a result is stuck at the output
  assign in_ready_o = ~out_valid_q | out_ready_i;

  assign in_en     = in_valid_i & in_ready_o;
  assign out_en    = out_valid_q & out_ready_i;
  assign burst_end = in_en & in_last_i;

  // ------------------------------
  // byte adder
  // ------------------------------
  always_comb begin
    beat_sum = '0;
    for (int i = 0; i < STRB_WIDTH; i++) begin
      if (in_strb_i[i]) begin
        beat_sum = beat_sum + data_t'(in_data_i[8*i +: 8]);  // masked lane
      end
    end
  end

  assign sum_next = sum_q + beat_sum;  // wraps mod 2**32
  assign cnt_next = cnt_q + 1'b1;

  // ------------------------------
  // running state
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sum_q       <= '0;
      cnt_q       <= '0;
      out_valid_q <= 1'b0;
    end else if (clear_i) begin
      sum_q       <= '0;
      cnt_q       <= '0;
      out_valid_q <= 1'b0;
    end else begin
      if (burst_end) begin
        sum_q <= '0;          // restart for the next burst
        cnt_q <= '0;
      end else if (in_en) begin
        sum_q <= sum_next;
        cnt_q <= cnt_next;
      end

      if (burst_end) begin
        out_valid_q <= 1'b1;  // also covers a reload in the transfer cycle
      end else if (out_en) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  // held result
  always_ff @(posedge clk_i) begin
    if (burst_end) begin
      res_sum_q <= sum_next;
      res_cnt_q <= cnt_next;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_sum_o   = res_sum_q;
  assign out_strb_o  = '1;  // result beats carry every byte
  assign out_cnt_o   = res_cnt_q;

  // ------------------------------
  // checks
  // ------------------------------
  // upstream must keep bursts to 255 beats or the count wraps
  a_burst_limit: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    in_en |-> (cnt_q != '1)
  ) else $error("burst longer than 255 beats");

  // a result is held unchanged until the consumer takes it
  a_out_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (out_valid_o && !out_ready_i && !clear_i) |=>
      out_valid_o && $stable(out_sum_o) && $stable(out_cnt_o)
  ) else $error("result dropped before transfer");

endmodule

// File: hdl/stream_reduce_top.sv
/*
 * Stream reduction top. Input FIFO, byte accumulator and result FIFO
 * in a three-stage valid/ready pipeline.
 */

`timescale 1ns/1ps

module stream_reduce_top
  import stream_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,

  // input stream
  input  logic        in_valid_i,
  output logic        in_ready_o,
  input  data_t       in_data_i,
  input  strb_t       in_strb_i,
  input  last_t       in_last_i,

  // result stream
  output logic        out_valid_o,
  input  logic        out_ready_i,
  output data_t       out_sum_o,
  output strb_t       out_strb_o,
  output beat_cnt_t   out_cnt_o,

  output flags_fifo_t in_flags_o,
  output flags_fifo_t out_flags_o
);

  // input FIFO to accumulator
  logic      fifo_valid, fifo_ready;
  data_t     fifo_data;
  strb_t     fifo_strb;
  last_t     fifo_last;

  // accumulator to result FIFO
  logic      acc_valid, acc_ready;
  data_t     acc_sum;
  strb_t     acc_strb;
  beat_cnt_t acc_cnt;

  // ------------------------------
  // stage 1, input buffer
  // ------------------------------
  stream_fifo_sidech #(
    .FIFO_DEPTH (IN_FIFO_DEPTH),
    .SIDECH_T   (last_t)
  ) i_in_fifo (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .flags_o       (in_flags_o),
    .push_valid_i  (in_valid_i),
    .push_ready_o  (in_ready_o),
    .push_data_i   (in_data_i),
    .push_strb_i   (in_strb_i),
    .push_sidech_i (in_last_i),
    .pop_valid_o   (fifo_valid),
    .pop_ready_i   (fifo_ready),
    .pop_data_o    (fifo_data),
    .pop_strb_o    (fifo_strb),
    .pop_sidech_o  (fifo_last)
  );

  // ------------------------------
  // stage 2, reduction
  // ------------------------------
  byte_accum i_accum (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .in_valid_i  (fifo_valid),
    .in_ready_o  (fifo_ready),
    .in_data_i   (fifo_data),
    .in_strb_i   (fifo_strb),
    .in_last_i   (fifo_last),
    .out_valid_o (acc_valid),
    .out_ready_i (acc_ready),
    .out_sum_o   (acc_sum),
    .out_strb_o  (acc_strb),
    .out_cnt_o   (acc_cnt)
  );

  // ------------------------------
  // stage 3, result buffer
  // ------------------------------
  stream_fifo_sidech #(
    .FIFO_DEPTH (OUT_FIFO_DEPTH),
    .SIDECH_T   (beat_cnt_t)
  ) i_out_fifo (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .flags_o       (out_flags_o),
    .push_valid_i  (acc_valid),
    .push_ready_o  (acc_ready),
    .push_data_i   (acc_sum),
    .push_strb_i   (acc_strb),
    .push_sidech_i (acc_cnt),
    .pop_valid_o   (out_valid_o),
    .pop_ready_i   (out_ready_i),
    .pop_data_o    (out_sum_o),
    .pop_strb_o    (out_strb_o),
    .pop_sidech_o  (out_cnt_o)
  );

endmodule

// File: include/tb_vectors.svh
/*
 * Stimulus table for the stream reduction testbench. One row per input beat,
 * expected sum and count filled in on the last beat of each burst.
 */

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef struct packed {
  data_t     data;
  strb_t     strb;
  last_t     last;
  data_t     exp_sum;  // only meaningful on last rows
  beat_cnt_t exp_cnt;
} vec_t;

localparam int NUM_ROWS   = 16;
localparam int NUM_BURSTS = 4;
localparam int C_FIRST    = 4;  // first row of the ten-beat burst

// columns: data, strb, last, expected sum, expected beat count
localparam vec_t VECTORS [NUM_ROWS] = '{
  '{32'h0102_0304, 4'b1111, 1'b1, 32'h0000_000A, 8'd1},   // 1+2+3+4
  '{32'h1122_3344, 4'b0101, 1'b0, 32'h0000_0000, 8'd0},   // lanes 0 and 2 -> 0x66
  '{32'hAABB_CCDD, 4'b0000, 1'b0, 32'h0000_0000, 8'd0},   // counts, adds nothing
  '{32'h0506_0708, 4'b1000, 1'b1, 32'h0000_006B, 8'd3},   // lane 3 -> 0x05
  '{32'h0101_0101, 4'b1111, 1'b0, 32'h0000_0000, 8'd0},
  '{32'h0202_0202, 4'b1111, 1'b0, 32'h0000_0000, 8'd0},
  '{32'h0303_0303, 4'b1111, 1'b0, 32'h0000_0000, 8'd0},
  '{32'h0404_0404, 4'b1111, 1'b0, 32'h0000_0000, 8'd0},
  '{32'h0505_0505, 4'b1111, 1'b0, 32'h0000_0000, 8'd0},
  '{32'h0606_0606, 4'b1111, 1'b0, 32'h0000_0000, 8'd0},
  '{32'h0707_0707, 4'b1111, 1'b0, 32'h0000_0000, 8'd0},
  '{32'h0808_0808, 4'b1111, 1'b0, 32'h0000_0000, 8'd0},
  '{32'h0909_0909, 4'b1111, 1'b0, 32'h0000_0000, 8'd0},
  '{32'h0A0A_0A0A, 4'b1111, 1'b1, 32'h0000_00DC, 8'd10},  // 4 * (1 + ... + 10)
  '{32'hFFFF_FFFF, 4'b1111, 1'b0, 32'h0000_0000, 8'd0},   // 1020
  '{32'h8000_0001, 4'b1001, 1'b1, 32'h0000_047D, 8'd2}    // + 0x80 + 0x01
};

`endif

// File: sim/tb_stream_reduce.sv
/*
 * Testbench for the stream reduction top. Drives table bursts, checks each
 * result beat in order, and covers back-pressure, clear and throttling.
 */

`timescale 1ns/1ps

module tb_stream_reduce
  import stream_pkg::*;
;

  `include "tb_vectors.svh"

  localparam int          TIMEOUT_CYCLES = 2000;
  localparam flags_fifo_t IDLE_FLAGS     = '{empty: 1'b1, full: 1'b0};
  localparam flags_fifo_t FULL_FLAGS     = '{empty: 1'b0, full: 1'b1};

  logic        clk_i, rst_ni, clear_i;
  logic        in_valid_i, in_ready_o, in_last_i;
  data_t       in_data_i;
  strb_t       in_strb_i;
  logic        out_valid_o, out_ready_i;
  data_t       out_sum_o;
  strb_t       out_strb_o;
  beat_cnt_t   out_cnt_o;
  flags_fifo_t in_flags_o, out_flags_o;

  data_t       exp_sum_q[$];  // results still owed by the DUT
  beat_cnt_t   exp_cnt_q[$];
  logic        throttling;

  stream_reduce_top stream_reduce_top_inst (.*);

  always #20 clk_i = ~clk_i;

  // ------------------------------
  // failure and compare tasks
  // ------------------------------
  task automatic abort_run();
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_strb(input string name, input strb_t exp, input strb_t act);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_cnt(input string name, input beat_cnt_t exp, input beat_cnt_t act);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flags(input string name, input flags_fifo_t exp,
                             input flags_fifo_t act);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  // ------------------------------
  // driver and monitor
  // ------------------------------
  // one beat per row, held until in_ready_o is seen before a rising edge
  task automatic drive_rows(input int first, input int last_row);
    int waited;
    @(posedge clk_i);
    for (int i = first; i <= last_row; i++) begin
      in_valid_i <= 1'b1;
      in_data_i  <= VECTORS[i].data;
      in_strb_i  <= VECTORS[i].strb;
      in_last_i  <= VECTORS[i].last;
      if (VECTORS[i].last) begin
        exp_sum_q.push_back(VECTORS[i].exp_sum);
        exp_cnt_q.push_back(VECTORS[i].exp_cnt);
      end
      waited = 0;
      @(negedge clk_i);
      while (!in_ready_o) begin
        waited++;
        if (waited > TIMEOUT_CYCLES) begin
          $display("timeout: input beat %0d never accepted", i);
          abort_run();
        end
        @(negedge clk_i);
      end
      @(posedge clk_i);  // beat transfers here
    end
    in_valid_i <= 1'b0;
  endtask

  task automatic collect_results(input int n);
    int        waited;
    data_t     exp_sum;
    beat_cnt_t exp_cnt;
    for (int k = 0; k < n; k++) begin
      waited = 0;
      @(negedge clk_i);
      while (!(out_valid_o && out_ready_i)) begin
        waited++;
        if (waited > TIMEOUT_CYCLES) begin
          $display("timeout: result %0d of %0d never arrived", k + 1, n);
          abort_run();
        end
        @(negedge clk_i);
      end
      if (exp_sum_q.size() == 0) begin
        $display("result beat arrived with no burst outstanding");
        abort_run();
      end
      exp_sum = exp_sum_q.pop_front();
      exp_cnt = exp_cnt_q.pop_front();
      check_data("out_sum_o", exp_sum, out_sum_o);
      check_strb("out_strb_o", '1, out_strb_o);
      check_cnt("out_cnt_o", exp_cnt, out_cnt_o);
      @(posedge clk_i);
    end
  endtask

  task automatic wait_input_full();
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!in_flags_o.full) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        $display("timeout: input FIFO never filled under back-pressure");
        abort_run();
      end
      @(negedge clk_i);
    end
  endtask

  // ------------------------------
  // scenarios
  // ------------------------------
  initial begin
    void'($urandom(35200));
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    clear_i     = 1'b0;
    in_valid_i  = 1'b0;
    in_data_i   = '0;
    in_strb_i   = '0;
    in_last_i   = 1'b0;
    out_ready_i = 1'b0;
    throttling  = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_flags("in_flags_o", IDLE_FLAGS, in_flags_o);
    check_flags("out_flags_o", IDLE_FLAGS, out_flags_o);
    if (!in_ready_o || out_valid_o) begin
      $display("handshake outputs wrong after reset");
      abort_run();
    end

    // single, partial-strobe and long bursts in order
    @(posedge clk_i);
    out_ready_i <= 1'b1;
    fork
      drive_rows(0, NUM_ROWS - 1);
      collect_results(NUM_BURSTS);
    join

    // back-pressure until the input FIFO fills, then drain
    @(posedge clk_i);
    out_ready_i <= 1'b0;
    fork
      begin
        drive_rows(0, NUM_ROWS - 1);
        drive_rows(0, NUM_ROWS - 1);
      end
      begin
        wait_input_full();
        check_flags("in_flags_o", FULL_FLAGS, in_flags_o);
        check_flags("out_flags_o", FULL_FLAGS, out_flags_o);
        if (in_ready_o) begin
          $display("in_ready_o high while the input FIFO is full");
          abort_run();
        end
        @(posedge clk_i);
        out_ready_i <= 1'b1;
      end
      collect_results(2 * NUM_BURSTS);
    join

    // clear in the middle of the long burst, two results still queued
    @(posedge clk_i);
    out_ready_i <= 1'b0;
    drive_rows(0, C_FIRST + 2);
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i <= 1'b0;
    exp_sum_q.delete();  // queued results are dropped by the clear
    exp_cnt_q.delete();
    @(negedge clk_i);
    if (out_valid_o || !in_ready_o) begin
      $display("handshake outputs wrong after clear");
      abort_run();
    end
    check_flags("in_flags_o", IDLE_FLAGS, in_flags_o);
    check_flags("out_flags_o", IDLE_FLAGS, out_flags_o);
    @(posedge clk_i);
    out_ready_i <= 1'b1;
    fork
      drive_rows(0, 0);
      collect_results(1);
    join

    // random output throttling over all bursts
    throttling = 1'b1;
    fork
      begin
        fork
          drive_rows(0, NUM_ROWS - 1);
          collect_results(NUM_BURSTS);
        join
        throttling = 1'b0;
      end
      begin
        int cycles;
        cycles = 0;
        while (throttling) begin
          @(posedge clk_i);
          out_ready_i <= 1'($urandom % 2);
          cycles++;
          if (cycles > 4 * TIMEOUT_CYCLES) begin
            $display("timeout: throttled run did not finish");
            abort_run();
          end
        end
      end
    join
    @(posedge clk_i);
    out_ready_i <= 1'b1;
    @(negedge clk_i);
    check_flags("in_flags_o", IDLE_FLAGS, in_flags_o);
    check_flags("out_flags_o", IDLE_FLAGS, out_flags_o);

    if (exp_sum_q.size() == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("%0d expected results never arrived", exp_sum_q.size());
      abort_run();
    end
  end

endmodule

// File: src.f
+incdir+include
hdl/stream_pkg.sv
hdl/stream_fifo_sidech.sv
hdl/byte_accum.sv
hdl/stream_reduce_top.sv
sim/tb_stream_reduce.sv

// File: Bender.yml
package:
  name: stream_reduce

sources:
  # package first, then the pipeline stages and the top level
  - hdl/stream_pkg.sv
  - hdl/stream_fifo_sidech.sv
  - hdl/byte_accum.sv
  - hdl/stream_reduce_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - sim/tb_stream_reduce.sv
